// ==== logic/memsys_pkg.sv ====
`default_nettype none

package memsys_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    // byte address
    localparam int addr_width = 32;
    // one memory word
    localparam int word_width = 64;
    // tag 0 means no tag
    localparam int tag_width = 4;
    localparam int tag_count = 1 << tag_width;

    // word index out of the byte address
    localparam int word_bytes = word_width / 8;
    localparam int offset_width = $clog2(word_bytes);

    ////////////////////
    // memory model
    ////////////////////

    // accepting edge to data return
    localparam int mem_latency = 4;
    localparam int mem_words = 256;
    localparam int index_width = $clog2(mem_words);

    ////////////////////
    // fetch
    ////////////////////

    localparam logic [addr_width-1:0] reset_pc = '0;
    // max fetch reads in flight
    localparam int fetch_depth = 4;
    localparam int fetch_count_width = $clog2(fetch_depth + 1);

    // bus commands
    typedef enum logic [1:0] {
        bus_none  = 2'h0,
        bus_load  = 2'h1,
        bus_store = 2'h2
    } bus_command_t;

    // who issued a tagged load
    typedef enum logic {
        owner_fetch = 1'b0,
        owner_data  = 1'b1
    } bus_owner_t;

endpackage

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`default_nettype none

module fetch_unit import memsys_pkg::*; (
    input  wire                    clock,
    input  wire                    reset,
    // level, fetch runs while high
    input  wire                    fetch_enable,
    // request side toward the arbiter
    output logic                   fetch_req,
    output logic [addr_width-1:0]  fetch_addr,
    input  wire                    fetch_grant,
    // routed returns from the arbiter
    input  wire                    fetch_rvalid,
    input  wire  [word_width-1:0]  fetch_rdata,
    // instruction stream out
    output logic                   inst_valid,
    output logic [addr_width-1:0]  inst_pc,
    output logic [word_width-1:0]  inst_data
);

    ////////////////////
    // state
    ////////////////////

    // next address to request
    logic [addr_width-1:0]        next_pc;
    // address of the next word to come back
    logic [addr_width-1:0]        expect_pc;
    // reads sent, not yet returned
    logic [fetch_count_width-1:0] inflight_count;
    // request went out this cycle
    logic                         fetch_taken;

    // stop asking once the window is full
    assign fetch_req   = fetch_enable && (inflight_count < fetch_count_width'(fetch_depth));
    assign fetch_addr  = next_pc;
    assign fetch_taken = fetch_req && fetch_grant;

    ////////////////////
    // request address
    ////////////////////

    // held while not granted
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            next_pc <= reset_pc;
        end else if (fetch_taken) begin
            next_pc <= next_pc + addr_width'(word_bytes);
        end
    end

    ////////////////////
    // in-flight count
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inflight_count <= '0;
        end else begin
            case ({fetch_taken, fetch_rvalid})
                // new read, nothing back
                2'b10: inflight_count <= inflight_count + 1'b1;
                // word back, no new read
                2'b01: inflight_count <= inflight_count - 1'b1;
                // both or neither, count unchanged
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    ////////////////////
    // return tracking
    ////////////////////

    // memory answers in order, so the pc is implied
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            expect_pc <= reset_pc;
        end else if (fetch_rvalid) begin
            expect_pc <= expect_pc + addr_width'(word_bytes);
        end
    end

    // pass each return straight out
    assign inst_valid = fetch_rvalid;
    assign inst_pc    = expect_pc;
    assign inst_data  = fetch_rdata;

    ////////////////////
    // checks
    ////////////////////

    // window never overfills
    a_inflight_bound: assert property (@(posedge clock) disable iff (reset)
        inflight_count <= fetch_count_width'(fetch_depth));

    // arbiter only routes words we asked for
    a_return_expected: assert property (@(posedge clock) disable iff (reset)
        fetch_rvalid |-> (inflight_count != '0));

endmodule

`default_nettype wire

// ==== logic/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter import memsys_pkg::*; (
    input  wire                    clock,
    input  wire                    reset,
    // data port, single-cycle strobe
    input  wire                    data_req,
    input  wire                    data_store,
    input  wire  [addr_width-1:0]  data_addr,
    input  wire  [word_width-1:0]  data_wdata,
    // fetch unit request
    input  wire                    fetch_req,
    input  wire  [addr_width-1:0]  fetch_addr,
    output logic                   fetch_grant,
    // memory request side
    output bus_command_t           mem_command,
    output logic [addr_width-1:0]  mem_addr,
    output logic [word_width-1:0]  mem_wdata,
    // memory answer side
    input  wire  [tag_width-1:0]   mem_response,
    input  wire  [tag_width-1:0]   mem_tag,
    input  wire  [word_width-1:0]  mem_rdata,
    // routed returns
    output logic                   fetch_rvalid,
    output logic [word_width-1:0]  fetch_rdata,
    output logic                   load_valid,
    output logic [word_width-1:0]  load_data
);

    ////////////////////
    // owner table
    ////////////////////

    // owner per tag, payload only
    bus_owner_t           owner_table [tag_count];
    // tag has a load outstanding
    logic [tag_count-1:0] tag_live;
    // owner of the load going out now
    bus_owner_t           issue_owner;
    // owner of the word coming back
    bus_owner_t           return_owner;
    logic                 return_hit;

    ////////////////////
    // selection
    ////////////////////

    // data side first, fetch fills idle cycles
    always_comb begin
        mem_command = bus_none;
        mem_addr    = '0;
        mem_wdata   = '0;
        fetch_grant = 1'b0;
        issue_owner = owner_fetch;
        if (data_req) begin
            mem_command = data_store ? bus_store : bus_load;
            mem_addr    = data_addr;
            mem_wdata   = data_wdata;
            issue_owner = owner_data;
        end else if (fetch_req) begin
            // instruction reads are plain loads
            mem_command = bus_load;
            mem_addr    = fetch_addr;
            fetch_grant = 1'b1;
        end
    end

    // record who owns the tag memory just handed out
    always_ff @(posedge clock) begin
        if (mem_command == bus_load) begin
            owner_table[mem_response] <= issue_owner;
        end
    end

    // live bits, set wins over clear
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tag_live <= '0;
        end else begin
            if (mem_tag != '0) begin
                tag_live[mem_tag] <= 1'b0;
            end
            if (mem_command == bus_load) begin
                tag_live[mem_response] <= 1'b1;
            end
        end
    end

    ////////////////////
    // return routing
    ////////////////////

    // tag 0 is an empty slot
    assign return_hit   = (mem_tag != '0);
    assign return_owner = owner_table[mem_tag];

    // exactly one strobe per returning tag
    assign fetch_rvalid = return_hit && (return_owner == owner_fetch);
    assign load_valid   = return_hit && (return_owner == owner_data);

    // same data bus for both, strobes pick the reader
    assign fetch_rdata = mem_rdata;
    assign load_data   = mem_rdata;

    ////////////////////
    // checks
    ////////////////////

    // each return matches a load we sent
    a_return_owned: assert property (@(posedge clock) disable iff (reset)
        return_hit |-> tag_live[mem_tag]);

    // memory always takes a load
    a_load_tagged: assert property (@(posedge clock) disable iff (reset)
        (mem_command == bus_load) |-> (mem_response != '0));

endmodule

`default_nettype wire

// ==== logic/tagged_memory.sv ====
`default_nettype none

module tagged_memory import memsys_pkg::*; (
    input  wire                    clock,
    input  wire                    reset,
    // request
    input  wire  bus_command_t     mem_command,
    input  wire  [addr_width-1:0]  mem_addr,
    input  wire  [word_width-1:0]  mem_wdata,
    // tag for this request, same cycle
    output logic [tag_width-1:0]   mem_response,
    // delayed return
    output logic [tag_width-1:0]   mem_tag,
    output logic [word_width-1:0]  mem_rdata
);

    ////////////////////
    // storage
    ////////////////////

    logic [word_width-1:0]  mem_array [mem_words];
    // bits 10 down to 3 pick the word
    logic [index_width-1:0] word_index;

    // next tag to hand out, never 0
    logic [tag_width-1:0]   next_tag;

    // return delay line, stage 0 loads at the accepting edge
    logic [tag_width-1:0]   tag_pipe  [mem_latency + 1];
    logic [word_width-1:0]  data_pipe [mem_latency + 1];

    assign word_index = mem_addr[offset_width +: index_width];

    // only loads get a tag
    assign mem_response = (mem_command == bus_load) ? next_tag : '0;

    // stores land at the accepting edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < mem_words; i++) begin
                mem_array[i] <= '0;
            end
        end else if (mem_command == bus_store) begin
            mem_array[word_index] <= mem_wdata;
        end
    end

    ////////////////////
    // tag counter
    ////////////////////

    // 1 .. 15 then wrap to 1
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            next_tag <= tag_width'(1);
        end else if (mem_command == bus_load) begin
            if (next_tag == tag_width'(tag_count - 1)) begin
                next_tag <= tag_width'(1);
            end else begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    ////////////////////
    // delay line
    ////////////////////

    // tags are control, empty after reset
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i <= mem_latency; i++) begin
                tag_pipe[i] <= '0;
            end
        end else begin
            tag_pipe[0] <= mem_response;
            for (int i = 1; i <= mem_latency; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    // read happens at accept, older store already in
    always_ff @(posedge clock) begin
        data_pipe[0] <= mem_array[word_index];
        for (int i = 1; i <= mem_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // last stage drives the bus, mem_latency edges after accept
    assign mem_tag   = tag_pipe[mem_latency];
    assign mem_rdata = data_pipe[mem_latency];

    ////////////////////
    // checks
    ////////////////////

    // a tag must not wrap while its load is still out
    a_latency_fits: assert property (@(posedge clock)
        mem_latency < (tag_count - 1));

endmodule

`default_nettype wire

// ==== logic/memsys_top.sv ====
`default_nettype none

module memsys_top import memsys_pkg::*; (
    input  wire                    clock,
    input  wire                    reset,
    // data port
    input  wire                    data_req,
    input  wire                    data_store,
    input  wire  [addr_width-1:0]  data_addr,
    input  wire  [word_width-1:0]  data_wdata,
    // fetch control
    input  wire                    fetch_enable,
    // load return
    output logic                   load_valid,
    output logic [word_width-1:0]  load_data,
    // instruction return
    output logic                   inst_valid,
    output logic [addr_width-1:0]  inst_pc,
    output logic [word_width-1:0]  inst_data
);

    ////////////////////
    // fetch to arbiter
    ////////////////////

    logic                  fetch_req;
    logic [addr_width-1:0] fetch_addr;
    logic                  fetch_grant;
    logic                  fetch_rvalid;
    logic [word_width-1:0] fetch_rdata;

    ////////////////////
    // arbiter to memory
    ////////////////////

    bus_command_t          mem_command;
    logic [addr_width-1:0] mem_addr;
    logic [word_width-1:0] mem_wdata;
    logic [tag_width-1:0]  mem_response;
    logic [tag_width-1:0]  mem_tag;
    logic [word_width-1:0] mem_rdata;

    // instruction stream source
    fetch_unit i_fetch_unit (
        .clock        (clock),
        .reset        (reset),
        .fetch_enable (fetch_enable),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_grant  (fetch_grant),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rdata  (fetch_rdata),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst_data    (inst_data)
    );

    // shared bus, data first
    bus_arbiter i_bus_arbiter (
        .clock        (clock),
        .reset        (reset),
        .data_req     (data_req),
        .data_store   (data_store),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_grant  (fetch_grant),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_rdata    (mem_rdata),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rdata  (fetch_rdata),
        .load_valid   (load_valid),
        .load_data    (load_data)
    );

    // fixed latency backing store
    tagged_memory i_tagged_memory (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_tag      (mem_tag),
        .mem_rdata    (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/memsys_tests.svh ====
////////////////////
// helpers
////////////////////

// words the fetch test fills with data
localparam int filled_words = 128;

// word index is address bits 10 down to 3
function automatic logic [index_width-1:0] index_of(input logic [addr_width-1:0] addr);
    return addr[10:3];
endfunction

// one cycle of the data port, model follows stores
task automatic drive_data(input logic store, input logic [addr_width-1:0] addr,
                          input logic [word_width-1:0] wdata);
    @(posedge clock);
    #drive_delay;
    data_req   = 1'b1;
    data_store = store;
    data_addr  = addr;
    data_wdata = wdata;
    if (store) begin
        model[index_of(addr)] = wdata;
    end else begin
        // accepted at the next edge, back mem_latency later
        load_expect.push_back(model[index_of(addr)]);
        load_expect_cycle.push_back(cycle_count + 1 + mem_latency);
    end
endtask

task automatic idle_data();
    @(posedge clock);
    #drive_delay;
    data_req   = 1'b0;
    data_store = 1'b0;
endtask

task automatic wait_loads(input int count, input int limit);
    int waited;
    waited = 0;
    while (load_seen.size() < count && waited < limit) begin
        @(posedge clock);
        waited++;
    end
    if (load_seen.size() < count) begin
        error_count++;
        $display("load_valid missing, %0d of %0d returns seen", load_seen.size(), count);
    end
endtask

task automatic wait_insts(input int count, input int limit);
    int waited;
    waited = 0;
    while (inst_seen_pc.size() < count && waited < limit) begin
        @(posedge clock);
        waited++;
    end
    if (inst_seen_pc.size() < count) begin
        error_count++;
        $display("inst_valid missing, %0d of %0d words seen", inst_seen_pc.size(), count);
    end
endtask

// pair returns with owed loads in request order
task automatic drain_loads();
    logic [word_width-1:0] got;
    int                    got_cycle;
    while (load_expect.size() != 0 && load_seen.size() != 0) begin
        got       = load_seen.pop_front();
        got_cycle = load_seen_cycle.pop_front();
        compare_load(got, load_expect.pop_front());
        compare_cycle(got_cycle, load_expect_cycle.pop_front());
    end
    if (load_seen.size() != 0) begin
        error_count++;
        $display("%0d load_valid strobes arrived with no load sent", load_seen.size());
    end
    load_expect.delete();
    load_expect_cycle.delete();
    load_seen.delete();
    load_seen_cycle.delete();
endtask

// a gap or a repeat breaks the pc sequence
task automatic drain_fetch();
    logic [addr_width-1:0] pc;
    logic [word_width-1:0] data;
    while (inst_seen_pc.size() != 0) begin
        pc   = inst_seen_pc.pop_front();
        data = inst_seen_data.pop_front();
        compare_inst(pc, data, fetch_expect_pc, model[index_of(fetch_expect_pc)]);
        fetch_expect_pc = fetch_expect_pc + addr_width'(word_bytes);
    end
endtask

task automatic report_test(input string name, input int errors_before);
    $display("%s done, %0d errors", name, error_count - errors_before);
endtask

////////////////////
// tests
////////////////////

task automatic quiet_after_reset();
    int errors_before;
    errors_before = error_count;
    repeat (20) @(posedge clock);
    check_count++;
    if (load_seen.size() != 0 || inst_seen_pc.size() != 0) begin
        error_count++;
        $display("strobes while idle: %0d load_valid, %0d inst_valid",
                 load_seen.size(), inst_seen_pc.size());
    end
    load_seen.delete();
    load_seen_cycle.delete();
    inst_seen_pc.delete();
    inst_seen_data.delete();
    report_test("quiet_after_reset", errors_before);
endtask

task automatic store_then_load();
    int                    errors_before;
    logic [addr_width-1:0] addrs [16];
    errors_before = error_count;
    for (int i = 0; i < 16; i++) begin
        addrs[i] = addr_width'(($urandom % mem_words) * word_bytes);
        drive_data(1'b1, addrs[i], {$urandom, $urandom});
    end
    idle_data();
    // one load at a time, latency checked on each
    for (int i = 0; i < 16; i++) begin
        drive_data(1'b0, addrs[i], '0);
        idle_data();
        wait_loads(1, mem_latency + 4);
        drain_loads();
    end
    report_test("store_then_load", errors_before);
endtask

task automatic back_to_back_loads();
    int                    errors_before;
    logic [addr_width-1:0] base;
    errors_before = error_count;
    base = addr_width'(($urandom % (mem_words - 8)) * word_bytes);
    // distinct words so the return order shows
    for (int i = 0; i < 8; i++) begin
        drive_data(1'b1, base + addr_width'(i * word_bytes), {$urandom, $urandom});
    end
    for (int i = 0; i < 8; i++) begin
        drive_data(1'b0, base + addr_width'(i * word_bytes), '0);
    end
    idle_data();
    wait_loads(8, mem_latency + 12);
    drain_loads();
    report_test("back_to_back_loads", errors_before);
endtask

task automatic sequential_fetch();
    int errors_before;
    errors_before = error_count;
    // past the first 32 too, so later fetches read real data
    for (int i = 0; i < filled_words; i++) begin
        drive_data(1'b1, addr_width'(i * word_bytes), {$urandom, $urandom});
    end
    idle_data();
    @(posedge clock);
    #drive_delay;
    fetch_enable = 1'b1;
    wait_insts(32, 2 * 32 + mem_latency + 8);
    drain_fetch();
    report_test("sequential_fetch", errors_before);
endtask

// fetch keeps running from the previous test
task automatic fetch_under_contention();
    int errors_before;
    int loads_sent;
    errors_before = error_count;
    loads_sent    = 0;
    for (int i = 0; i < 40; i++) begin
        if ($urandom % 3 == 0) begin
            drive_data(1'b0, addr_width'(($urandom % filled_words) * word_bytes), '0);
            loads_sent++;
        end else begin
            idle_data();
        end
    end
    idle_data();
    wait_loads(loads_sent, mem_latency + 8);
    drain_loads();
    @(posedge clock);
    #drive_delay;
    fetch_enable = 1'b0;
    // let the in-flight reads come home
    repeat (mem_latency + fetch_depth) @(posedge clock);
    drain_fetch();
    report_test("fetch_under_contention", errors_before);
endtask

// ==== tb/memsys_tb.sv ====
`default_nettype none

module memsys_tb import memsys_pkg::*; ();

    // input change point after each rising edge
    localparam int drive_delay = 10;
    // tests take roughly 1000 cycles in all
    localparam int cycle_limit = 3000;

    logic                  clock;
    logic                  reset;
    logic                  data_req;
    logic                  data_store;
    logic [addr_width-1:0] data_addr;
    logic [word_width-1:0] data_wdata;
    logic                  fetch_enable;
    logic                  load_valid;
    logic [word_width-1:0] load_data;
    logic                  inst_valid;
    logic [addr_width-1:0] inst_pc;
    logic [word_width-1:0] inst_data;

    int cycle_count;
    int check_count;
    int error_count;

    // mirror of every store, memory clears on reset
    logic [word_width-1:0] model [mem_words];

    // returns captured at the falling edge
    logic [word_width-1:0] load_seen [$];
    int                    load_seen_cycle [$];
    logic [addr_width-1:0] inst_seen_pc [$];
    logic [word_width-1:0] inst_seen_data [$];

    // loads still owed, oldest first
    logic [word_width-1:0] load_expect [$];
    int                    load_expect_cycle [$];
    // next pc the instruction stream must show
    logic [addr_width-1:0] fetch_expect_pc;

    memsys_top i_memsys_top (
        .clock        (clock),
        .reset        (reset),
        .data_req     (data_req),
        .data_store   (data_store),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .fetch_enable (fetch_enable),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst_data    (inst_data)
    );

    ////////////////////
    // clock and limit
    ////////////////////

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT never finished a test", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clock) begin
        if (load_valid) begin
            load_seen.push_back(load_data);
            load_seen_cycle.push_back(cycle_count);
        end
        if (inst_valid) begin
            inst_seen_pc.push_back(inst_pc);
            inst_seen_data.push_back(inst_data);
        end
    end

    ////////////////////
    // compare
    ////////////////////

    task automatic compare_load(input logic [word_width-1:0] got,
                                input logic [word_width-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail at %0t: load_data %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic compare_inst(input logic [addr_width-1:0] got_pc,
                                input logic [word_width-1:0] got_data,
                                input logic [addr_width-1:0] exp_pc,
                                input logic [word_width-1:0] exp_data);
        check_count++;
        if (got_pc !== exp_pc || got_data !== exp_data) begin
            error_count++;
            $display("Fail at %0t: inst_pc %h data %h, expected pc %h data %h",
                     $time, got_pc, got_data, exp_pc, exp_data);
        end
    endtask

    // return cycle of a load strobe
    task automatic compare_cycle(input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("Fail at %0t: load_valid in cycle %0d, expected cycle %0d",
                     $time, got, expected);
        end
    endtask

    `include "memsys_tests.svh"

    initial begin
        void'($urandom(32'h4cd9));
        clock           = 1'b0;
        reset           = 1'b1;
        data_req        = 1'b0;
        data_store      = 1'b0;
        data_addr       = '0;
        data_wdata      = '0;
        fetch_enable    = 1'b0;
        cycle_count     = 0;
        check_count     = 0;
        error_count     = 0;
        fetch_expect_pc = reset_pc;
        for (int i = 0; i < mem_words; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clock);
        #drive_delay;
        reset = 1'b0;

        quiet_after_reset();
        store_then_load();
        back_to_back_loads();
        sequential_fetch();
        fetch_under_contention();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/memsys_pkg.sv
logic/fetch_unit.sv
logic/bus_arbiter.sv
logic/tagged_memory.sv
logic/memsys_top.sv
+incdir+tb
tb/memsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module memsys_tb -o memsys_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/memsys_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only when the testbench printed its pass line
if echo "$output" | grep -q "^Test OK$"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
